// ==== Makefile ====
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= decode_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/decode_defs.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+rtl
rtl/decode_pkg.sv
rtl/basic_decoder.sv
rtl/operand_extract.sv
rtl/decoder.sv
rtl/decode_stage.sv
tests/decode_chk.sv
tests/decode_tb.sv

// ==== rtl/basic_decoder.sv ====
`timescale 1ns/10ps

module basic_decoder (
    input  decode_pkg::word_t        inst,
    output decode_pkg::decode_info_t info
);

    import decode_pkg::*;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;

    logic        is_3r;
    logic        is_shi;
    logic        is_i12;
    logic        is_upper;
    logic        is_mem;
    logic        is_br;
    logic        i12_zext;
    logic        mem_wr;
    logic        mem_sg;
    logic [1:0]  mem_sz;
    alu_op_t     alu_r;
    alu_op_t     alu_i;
    br_type_t    br_sel;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];

    // 3R and shift-immediate forms share the 17-bit opcode
    always_comb begin
        is_3r  = 1'b1;
        is_shi = 1'b0;
        alu_r  = alu_add;
        case (op17)
            17'h00020: alu_r = alu_add;
            17'h00022: alu_r = alu_sub;
            17'h00024: alu_r = alu_slt;
            17'h00025: alu_r = alu_sltu;
            17'h00028: alu_r = alu_nor;
            17'h00029: alu_r = alu_and;
            17'h0002a: alu_r = alu_or;
            17'h0002b: alu_r = alu_xor;
            17'h0002e: alu_r = alu_sll;
            17'h0002f: alu_r = alu_srl;
            17'h00030: alu_r = alu_sra;
            17'h00081: begin is_3r = 1'b0; is_shi = 1'b1; alu_r = alu_sll; end
            17'h00089: begin is_3r = 1'b0; is_shi = 1'b1; alu_r = alu_srl; end
            17'h00091: begin is_3r = 1'b0; is_shi = 1'b1; alu_r = alu_sra; end
            default:   is_3r = 1'b0;
        endcase
    end

    // 12-bit immediate alu and loads/stores
    always_comb begin
        is_i12   = 1'b1;
        i12_zext = 1'b0;
        alu_i    = alu_add;
        case (op10)
            10'h008: alu_i = alu_slt;
            10'h009: alu_i = alu_sltu;
            10'h00a: alu_i = alu_add;
            10'h00d: begin alu_i = alu_and; i12_zext = 1'b1; end
            10'h00e: begin alu_i = alu_or;  i12_zext = 1'b1; end
            10'h00f: begin alu_i = alu_xor; i12_zext = 1'b1; end
            default: is_i12 = 1'b0;
        endcase
    end

    // size lives in the low opcode bits for every ld/st
    assign mem_sz = op10[1:0];

    always_comb begin
        is_mem = 1'b1;
        mem_wr = 1'b0;
        mem_sg = 1'b0;
        case (op10)
            10'h0a0, 10'h0a1, 10'h0a2: mem_sg = 1'b1;
            10'h0a4, 10'h0a5, 10'h0a6: mem_wr = 1'b1;
            10'h0a8, 10'h0a9:          mem_sg = 1'b0;
            default:                   is_mem = 1'b0;
        endcase
    end

    // lu12i.w and pcaddu12i
    assign is_upper = (op7 == 7'h0a) || (op7 == 7'h0e);

    always_comb begin
        is_br  = 1'b1;
        br_sel = br_none;
        case (op6)
            6'h13:   br_sel = br_jirl;
            6'h14:   br_sel = br_b;
            6'h15:   br_sel = br_bl;
            6'h16:   br_sel = br_beq;
            6'h17:   br_sel = br_bne;
            6'h18:   br_sel = br_blt;
            6'h19:   br_sel = br_bge;
            6'h1a:   br_sel = br_bltu;
            6'h1b:   br_sel = br_bgeu;
            default: is_br  = 1'b0;
        endcase
    end

    always_comb begin
        info      = '0;
        info.inst = inst;
        if (is_3r) begin
            info.reg_type_r0 = rs_rj;
            info.reg_type_r1 = rs_rk;
            info.reg_type_w  = ws_rd;
            info.alu_op      = alu_r;
        end else if (is_shi) begin
            info.reg_type_r0 = rs_rj;
            info.reg_type_r1 = rs_imm;
            info.reg_type_w  = ws_rd;
            info.imm_type    = imm_u5;
            info.alu_op      = alu_r;
        end else if (is_i12) begin
            info.reg_type_r0 = rs_rj;
            info.reg_type_r1 = rs_imm;
            info.reg_type_w  = ws_rd;
            info.imm_type    = i12_zext ? imm_u12 : imm_s12;
            info.alu_op      = alu_i;
        end else if (is_upper) begin
            info.reg_type_r0 = rs_zero;
            info.reg_type_r1 = rs_imm;
            info.reg_type_w  = ws_rd;
            info.imm_type    = imm_s20;
            // pcaddu12i adds to pc in the alu
            info.alu_op      = op7[2] ? alu_add : alu_lui;
        end else if (is_mem) begin
            info.unit          = unit_lsu;
            info.reg_type_r0   = rs_rj;
            info.reg_type_r1   = mem_wr ? rs_rd : rs_imm;
            info.reg_type_w    = mem_wr ? ws_none : ws_rd;
            info.addr_imm_type = aimm_s12;
            info.mem_write     = mem_wr;
            info.mem_size      = mem_sz;
            info.mem_signed    = mem_sg;
        end else if (is_br) begin
            info.unit    = unit_bru;
            info.br_type = br_sel;
            case (br_sel)
                br_b: info.addr_imm_type = aimm_s26;
                br_bl: begin
                    info.reg_type_w    = ws_r1;
                    info.addr_imm_type = aimm_s26;
                end
                br_jirl: begin
                    info.reg_type_r0   = rs_rj;
                    info.reg_type_w    = ws_rd;
                    info.addr_imm_type = aimm_s16;
                end
                // compare rj against rd
                default: begin
                    info.reg_type_r0   = rs_rj;
                    info.reg_type_r1   = rs_rd;
                    info.addr_imm_type = aimm_s16;
                end
            endcase
        end else begin
            info.decode_err = 1'b1;
        end
    end

endmodule

// ==== rtl/decode_defs.svh ====
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// instructions carried by one fetch packet
`define DEC_LANES 2

// architectural register id width, 32 GPRs
`define ARF_W 5

// data path and address width
`define XLEN 32

// fetch packets are 8-byte aligned, lane n sits at pc + 4*n
`define LANE_BYTES 4

`endif

// ==== rtl/decode_pkg.sv ====
`include "decode_defs.svh"

package decode_pkg;

    // register id and machine word
    typedef logic [`ARF_W-1:0] arf_id_t;
    typedef logic [`XLEN-1:0]  word_t;

    // where a read operand comes from
    typedef enum logic [2:0] {
        rs_zero, rs_rd, rs_rj, rs_rk, rs_imm
    } reg_sel_t;

    // which field names the destination
    typedef enum logic [1:0] {
        ws_none, ws_rd, ws_rj, ws_r1
    } reg_w_sel_t;

    typedef enum logic [1:0] {
        imm_s12, imm_u12, imm_u5, imm_s20
    } imm_type_t;

    // branch and memory offsets
    typedef enum logic [1:0] {
        aimm_s12, aimm_s16, aimm_s26
    } addr_imm_type_t;

    typedef enum logic [1:0] {
        unit_alu, unit_lsu, unit_bru
    } unit_t;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu,
        br_b, br_bl, br_jirl
    } br_type_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or,
        alu_xor, alu_nor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    // per-instruction result of the opcode match
    typedef struct packed {
        word_t          inst;
        reg_sel_t       reg_type_r0;
        reg_sel_t       reg_type_r1;
        reg_w_sel_t     reg_type_w;
        imm_type_t      imm_type;
        addr_imm_type_t addr_imm_type;
        unit_t          unit;
        alu_op_t        alu_op;
        br_type_t       br_type;
        logic           mem_write;
        logic [1:0]     mem_size;
        logic           mem_signed;
        logic           decode_err;
    } decode_info_t;

    // fetch to decode
    typedef struct packed {
        word_t                        pc;
        word_t [`DEC_LANES-1:0]       insts;
        logic [`DEC_LANES-1:0]        mask;
    } f_d_pkg_t;

    // decode to rename, sources of lane n at index 2n and 2n+1
    typedef struct packed {
        logic [`DEC_LANES-1:0]          r_valid;
        word_t [`DEC_LANES-1:0]         pc;
        arf_id_t [2*`DEC_LANES-1:0]     r_id;
        arf_id_t [`DEC_LANES-1:0]       w_id;
        logic [2*`DEC_LANES-1:0]        reg_need;
        logic [2*`DEC_LANES-1:0]        use_imm;
        logic [`DEC_LANES-1:0]          w_reg;
        logic [`DEC_LANES-1:0]          w_mem;
        word_t [`DEC_LANES-1:0]         data_imm;
        word_t [`DEC_LANES-1:0]         addr_imm;
        unit_t [`DEC_LANES-1:0]         unit;
        alu_op_t [`DEC_LANES-1:0]       alu_op;
        br_type_t [`DEC_LANES-1:0]      br_type;
        logic [`DEC_LANES-1:0][1:0]     msize;
        logic [`DEC_LANES-1:0]          msigned;
        logic [`DEC_LANES-1:0]          decode_err;
    } d_r_pkg_t;

endpackage

// ==== rtl/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,

    // from fetch
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::f_d_pkg_t in_pkt,

    // to rename
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::d_r_pkg_t out_pkt
);

    import decode_pkg::*;

    logic     full;
    logic     load;
    f_d_pkg_t pkt_q;

    // accept when empty or when the held packet leaves this cycle
    assign in_ready = !full || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            // refill on transfer, otherwise the register drains
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pkt_q <= in_pkt;
        end
    end

    assign out_valid = full;

    // decode straight off the held packet
    decoder i_decoder (
        .f_pkg (pkt_q),
        .r_pkg (out_pkt)
    );

endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/10ps
`include "decode_defs.svh"

module decoder (
    input  decode_pkg::f_d_pkg_t f_pkg,
    output decode_pkg::d_r_pkg_t r_pkg
);

    import decode_pkg::*;

    decode_info_t       info     [`DEC_LANES];
    arf_id_t [1:0]      r_id     [`DEC_LANES];
    arf_id_t            w_id     [`DEC_LANES];
    word_t              data_imm [`DEC_LANES];
    word_t              addr_imm [`DEC_LANES];

    for (genvar i = 0; i < `DEC_LANES; i++) begin : g_lane
        basic_decoder i_basic_decoder (
            .inst (f_pkg.insts[i]),
            .info (info[i])
        );

        operand_extract i_operand_extract (
            .info     (info[i]),
            .r_id     (r_id[i]),
            .w_id     (w_id[i]),
            .data_imm (data_imm[i]),
            .addr_imm (addr_imm[i])
        );
    end

    always_comb begin
        for (int i = 0; i < `DEC_LANES; i++) begin
            r_pkg.r_valid[i] = f_pkg.mask[i];
            // aligned packet, so or-ing in the lane offset is an add
            r_pkg.pc[i]      = f_pkg.pc | word_t'(i * `LANE_BYTES);

            r_pkg.r_id[2*i]     = r_id[i][0];
            r_pkg.r_id[2*i+1]   = r_id[i][1];
            r_pkg.w_id[i]       = w_id[i];

            r_pkg.reg_need[2*i]   = (info[i].reg_type_r0 != rs_zero) &&
                                    (info[i].reg_type_r0 != rs_imm);
            r_pkg.reg_need[2*i+1] = (info[i].reg_type_r1 != rs_zero) &&
                                    (info[i].reg_type_r1 != rs_imm);
            r_pkg.use_imm[2*i]    = info[i].reg_type_r0 == rs_imm;
            r_pkg.use_imm[2*i+1]  = info[i].reg_type_r1 == rs_imm;

            r_pkg.w_reg[i]      = info[i].reg_type_w != ws_none;
            r_pkg.w_mem[i]      = info[i].mem_write;
            r_pkg.data_imm[i]   = data_imm[i];
            r_pkg.addr_imm[i]   = addr_imm[i];

            r_pkg.unit[i]       = info[i].unit;
            r_pkg.alu_op[i]     = info[i].alu_op;
            r_pkg.br_type[i]    = info[i].br_type;
            r_pkg.msize[i]      = info[i].mem_size;
            r_pkg.msigned[i]    = info[i].mem_signed;
            r_pkg.decode_err[i] = info[i].decode_err;
        end
    end

endmodule

// ==== rtl/operand_extract.sv ====
`timescale 1ns/10ps

module operand_extract (
    input  decode_pkg::decode_info_t  info,
    output decode_pkg::arf_id_t [1:0] r_id,
    output decode_pkg::arf_id_t       w_id,
    output decode_pkg::word_t         data_imm,
    output decode_pkg::word_t         addr_imm
);

    import decode_pkg::*;

    arf_id_t rd;
    arf_id_t rj;
    arf_id_t rk;

    assign rd = info.inst[4:0];
    assign rj = info.inst[9:5];
    assign rk = info.inst[14:10];

    // zero and imm both read r0
    function automatic arf_id_t sel_read(input reg_sel_t sel, input arf_id_t f_rd,
                                         input arf_id_t f_rj, input arf_id_t f_rk);
        arf_id_t id;
        case (sel)
            rs_rd:   id = f_rd;
            rs_rj:   id = f_rj;
            rs_rk:   id = f_rk;
            default: id = '0;
        endcase
        return id;
    endfunction

    assign r_id[0] = sel_read(info.reg_type_r0, rd, rj, rk);
    assign r_id[1] = sel_read(info.reg_type_r1, rd, rj, rk);

    always_comb begin
        case (info.reg_type_w)
            ws_rd:   w_id = rd;
            ws_rj:   w_id = rj;
            // link register of bl
            ws_r1:   w_id = arf_id_t'(1);
            default: w_id = '0;
        endcase
    end

    always_comb begin
        case (info.imm_type)
            imm_s12: data_imm = {{20{info.inst[21]}}, info.inst[21:10]};
            imm_u12: data_imm = {20'b0, info.inst[21:10]};
            imm_u5:  data_imm = {27'b0, info.inst[14:10]};
            default: data_imm = {{12{info.inst[24]}}, info.inst[24:5]};
        endcase
    end

    // branch offsets count words, so two zero bits go below
    always_comb begin
        case (info.addr_imm_type)
            aimm_s12: addr_imm = {{20{info.inst[21]}}, info.inst[21:10]};
            aimm_s16: addr_imm = {{14{info.inst[25]}}, info.inst[25:10], 2'b00};
            default:  addr_imm = {{4{info.inst[9]}}, info.inst[9:0], info.inst[25:10], 2'b00};
        endcase
    end

endmodule

// ==== tests/decode_chk.sv ====
`timescale 1ns/10ps
`include "decode_defs.svh"

module decode_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic                 in_ready,
    input decode_pkg::f_d_pkg_t in_pkt,
    input logic                 out_valid,
    input logic                 out_ready,
    input decode_pkg::d_r_pkg_t out_pkt
);

    import decode_pkg::*;

    logic seen_in;

    // set by the first input transfer after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_in <= 1'b0;
        end else if (in_valid && in_ready) begin
            seen_in <= 1'b1;
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_in |-> !out_valid)
        else $error("output valid before any input transfer");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt))
        else $error("output packet changed under back-pressure");

    // the presented packet carries the accepted mask and pc
    a_load: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |=> out_valid &&
        out_pkt.r_valid == $past(in_pkt.mask) && out_pkt.pc[0] == $past(in_pkt.pc))
        else $error("accepted packet not presented on the next cycle");

    a_lane_pc: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_pkt.pc[1] == (out_pkt.pc[0] | 32'h4))
        else $error("lane 1 pc is not the packet pc with bit 2 set");

    for (genvar i = 0; i < `DEC_LANES; i++) begin : g_lane
        a_err: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid && out_pkt.decode_err[i] |->
            !out_pkt.reg_need[2*i] && !out_pkt.reg_need[2*i+1] && !out_pkt.w_reg[i])
            else $error("invalid word still needs or writes registers");

        // link register of bl
        a_bl: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid && out_pkt.br_type[i] == br_bl |->
            out_pkt.w_id[i] == 5'd1 && out_pkt.w_reg[i])
            else $error("bl does not write r1");

        a_br_imm: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid && out_pkt.unit[i] == unit_bru |->
            !out_pkt.use_imm[2*i] && !out_pkt.use_imm[2*i+1])
            else $error("branch source marked as immediate");
    end

endmodule

bind decode_stage decode_chk i_decode_chk (.*);

// ==== tests/decode_tb.sv ====
`timescale 1ns/10ps

module decode_tb;

    import decode_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int N_TMPL  = 39;

    // opcodes left-aligned with free fields zero
    localparam word_t OPS [0:N_TMPL-1] = '{
        32'h00100000, 32'h00110000, 32'h00120000, 32'h00128000, 32'h00140000,
        32'h00148000, 32'h00150000, 32'h00158000, 32'h00170000, 32'h00178000,
        32'h00180000, 32'h00408000, 32'h00448000, 32'h00488000,
        32'h02000000, 32'h02400000, 32'h02800000, 32'h03400000, 32'h03800000,
        32'h03c00000, 32'h28000000, 32'h28400000, 32'h28800000, 32'h29000000,
        32'h29400000, 32'h29800000, 32'h2a000000, 32'h2a400000,
        32'h14000000, 32'h1c000000,
        32'h4c000000, 32'h50000000, 32'h54000000, 32'h58000000, 32'h5c000000,
        32'h60000000, 32'h64000000, 32'h68000000, 32'h6c000000
    };

    // read select codes of the model
    localparam int S_ZERO = 0;
    localparam int S_RD   = 1;
    localparam int S_RJ   = 2;
    localparam int S_RK   = 3;
    localparam int S_IMM  = 4;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    f_d_pkg_t in_pkt;
    logic     out_valid;
    logic     out_ready;
    d_r_pkg_t out_pkt;
    integer   seed;
    f_d_pkg_t exp_q [$];

    decode_stage i_decode_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    always #2 clk = !clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        assert (got === exp)
            else fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    function automatic arf_id_t pick_id(input int sel, input word_t i);
        case (sel)
            S_RD:    return i[4:0];
            S_RJ:    return i[9:5];
            S_RK:    return i[14:10];
            default: return 5'd0;
        endcase
    endfunction

    function automatic void model_lane(input word_t i, input int l, inout d_r_pkg_t e);
        int  s0;
        int  s1;
        int  wsel;
        logic u12;
        logic u5;
        logic s20;
        logic a16;
        logic a26;
        logic st;
        s0 = S_ZERO;
        s1 = S_ZERO;
        wsel = 0;
        {u12, u5, s20, a16, a26, st} = 6'b0;
        if (i[31:15] inside {17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29, 17'h2a,
                             17'h2b, 17'h2e, 17'h2f, 17'h30}) begin
            s0 = S_RJ;
            s1 = S_RK;
            wsel = 1;
            case (i[31:15])
                17'h22:  e.alu_op[l] = alu_sub;
                17'h24:  e.alu_op[l] = alu_slt;
                17'h25:  e.alu_op[l] = alu_sltu;
                17'h28:  e.alu_op[l] = alu_nor;
                17'h29:  e.alu_op[l] = alu_and;
                17'h2a:  e.alu_op[l] = alu_or;
                17'h2b:  e.alu_op[l] = alu_xor;
                17'h2e:  e.alu_op[l] = alu_sll;
                17'h2f:  e.alu_op[l] = alu_srl;
                17'h30:  e.alu_op[l] = alu_sra;
                default: e.alu_op[l] = alu_add;
            endcase
        end else if (i[31:15] inside {17'h81, 17'h89, 17'h91}) begin
            s0 = S_RJ;
            s1 = S_IMM;
            wsel = 1;
            u5 = 1'b1;
            e.alu_op[l] = i[19] ? alu_sra : (i[18] ? alu_srl : alu_sll);
        end else if (i[31:22] inside {10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e,
                                      10'h00f}) begin
            s0 = S_RJ;
            s1 = S_IMM;
            wsel = 1;
            u12 = i[24];
            case (i[25:22])
                4'h8:    e.alu_op[l] = alu_slt;
                4'h9:    e.alu_op[l] = alu_sltu;
                4'hd:    e.alu_op[l] = alu_and;
                4'he:    e.alu_op[l] = alu_or;
                4'hf:    e.alu_op[l] = alu_xor;
                default: e.alu_op[l] = alu_add;
            endcase
        end else if (i[31:25] == 7'h0a || i[31:25] == 7'h0e) begin
            s1 = S_IMM;
            wsel = 1;
            s20 = 1'b1;
            e.alu_op[l] = (i[31:25] == 7'h0a) ? alu_lui : alu_add;
        end else if (i[31:22] inside {10'h0a0, 10'h0a1, 10'h0a2, 10'h0a4, 10'h0a5,
                                      10'h0a6, 10'h0a8, 10'h0a9}) begin
            st = (i[25:22] >= 4'h4) && (i[25:22] <= 4'h6);
            s0 = S_RJ;
            s1 = st ? S_RD : S_IMM;
            wsel = st ? 0 : 1;
            e.unit[l] = unit_lsu;
            e.msize[l] = i[23:22];
            e.msigned[l] = (i[25:22] <= 4'h2);
        end else if (i[31:26] >= 6'h13 && i[31:26] <= 6'h1b) begin
            e.unit[l] = unit_bru;
            a16 = 1'b1;
            case (i[31:26])
                6'h13: begin
                    e.br_type[l] = br_jirl;
                    s0 = S_RJ;
                    wsel = 1;
                end
                6'h14: begin
                    e.br_type[l] = br_b;
                    a26 = 1'b1;
                end
                6'h15: begin
                    e.br_type[l] = br_bl;
                    a26 = 1'b1;
                    wsel = 2;
                end
                default: begin
                    s0 = S_RJ;
                    s1 = S_RD;
                    e.br_type[l] = br_type_t'(i[29:26] - 4'h5);
                end
            endcase
        end else begin
            e.decode_err[l] = 1'b1;
        end
        e.r_id[2*l]       = pick_id(s0, i);
        e.r_id[2*l+1]     = pick_id(s1, i);
        e.reg_need[2*l]   = (s0 != S_ZERO) && (s0 != S_IMM);
        e.reg_need[2*l+1] = (s1 != S_ZERO) && (s1 != S_IMM);
        e.use_imm[2*l]    = (s0 == S_IMM);
        e.use_imm[2*l+1]  = (s1 == S_IMM);
        e.w_reg[l]        = (wsel != 0);
        e.w_id[l]         = (wsel == 1) ? i[4:0] : ((wsel == 2) ? 5'd1 : 5'd0);
        e.w_mem[l]        = st;
        if (u5) e.data_imm[l] = {27'b0, i[14:10]};
        else if (u12) e.data_imm[l] = {20'b0, i[21:10]};
        else if (s20) e.data_imm[l] = {{12{i[24]}}, i[24:5]};
        else e.data_imm[l] = {{20{i[21]}}, i[21:10]};
        if (a26) e.addr_imm[l] = {{4{i[9]}}, i[9:0], i[25:10], 2'b00};
        else if (a16) e.addr_imm[l] = {{14{i[25]}}, i[25:10], 2'b00};
        else e.addr_imm[l] = {{20{i[21]}}, i[21:10]};
    endfunction

    function automatic d_r_pkg_t model_packet(input f_d_pkg_t p);
        d_r_pkg_t e;
        e = '0;
        for (int l = 0; l < 2; l++) begin
            model_lane(p.insts[l], l, e);
        end
        e.r_valid = p.mask;
        e.pc[0]   = p.pc;
        e.pc[1]   = p.pc | 32'h4;
        return e;
    endfunction

    function automatic word_t make_inst(input int k, input word_t rnd);
        int w;
        w = (k < 14) ? 17 : ((k < 28) ? 10 : ((k < 30) ? 7 : 6));
        return OPS[k] | (rnd & (32'hffffffff >> w));
    endfunction

    task automatic send_pkt(input f_d_pkg_t p, input int gap);
        int waited;
        waited = 0;
        in_valid = 1'b1;
        in_pkt = p;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > TIMEOUT) fail_run("input handshake timed out");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // output monitor sampled mid-cycle where everything is settled
    initial begin
        d_r_pkg_t e;
        forever begin
            @(negedge clk);
            if (rst_n && out_valid && out_ready) begin
                assert (exp_q.size() > 0) else fail_run("output with no accepted packet");
                e = model_packet(exp_q.pop_front());
                compare_field("r_valid", 128'(out_pkt.r_valid), 128'(e.r_valid));
                compare_field("pc", 128'(out_pkt.pc), 128'(e.pc));
                compare_field("r_id", 128'(out_pkt.r_id), 128'(e.r_id));
                compare_field("w_id", 128'(out_pkt.w_id), 128'(e.w_id));
                compare_field("reg_need", 128'(out_pkt.reg_need), 128'(e.reg_need));
                compare_field("use_imm", 128'(out_pkt.use_imm), 128'(e.use_imm));
                compare_field("w_reg", 128'(out_pkt.w_reg), 128'(e.w_reg));
                compare_field("w_mem", 128'(out_pkt.w_mem), 128'(e.w_mem));
                compare_field("data_imm", 128'(out_pkt.data_imm), 128'(e.data_imm));
                compare_field("addr_imm", 128'(out_pkt.addr_imm), 128'(e.addr_imm));
                compare_field("unit", 128'(out_pkt.unit), 128'(e.unit));
                compare_field("alu_op", 128'(out_pkt.alu_op), 128'(e.alu_op));
                compare_field("br_type", 128'(out_pkt.br_type), 128'(e.br_type));
                compare_field("msize", 128'(out_pkt.msize), 128'(e.msize));
                compare_field("msigned", 128'(out_pkt.msigned), 128'(e.msigned));
                compare_field("decode_err", 128'(out_pkt.decode_err), 128'(e.decode_err));
            end
            if (rst_n && in_valid && in_ready) begin
                exp_q.push_back(in_pkt);
            end
        end
    end

    // downstream throttling with ready about three cycles in four
    initial begin
        word_t r;
        forever begin
            @(negedge clk);
            r = $random(seed);
            @(posedge clk);
            #1;
            out_ready = (r[1:0] != 2'b00);
        end
    end

    initial begin
        f_d_pkg_t p;
        word_t    r;
        int       waited;
        seed = 5;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_pkt = '0;
        out_ready = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // two subset templates per packet
        for (int k = 0; k < N_TMPL; k += 2) begin
            p.pc = 32'h1c000000 + 32'(k * 8);
            p.insts[0] = make_inst(k, $random(seed));
            p.insts[1] = make_inst((k + 1) % N_TMPL, $random(seed));
            p.mask = 2'b11;
            send_pkt(p, 0);
        end
        // words outside the subset
        p.pc = 32'h00000ff8;
        p.insts[0] = 32'h00000000;
        p.insts[1] = 32'hffffffff;
        p.mask = 2'b11;
        send_pkt(p, 1);
        p.insts[0] = 32'h38000000;
        p.mask = 2'b01;
        send_pkt(p, 0);
        for (int n = 0; n < 300; n++) begin
            for (int l = 0; l < 2; l++) begin
                r = $random(seed);
                if (r[3:0] < 4'd3) p.insts[l] = $random(seed);
                else p.insts[l] = make_inst(int'({$random(seed)} % N_TMPL), $random(seed));
            end
            r = $random(seed);
            p.pc = r & 32'hfffffff8;
            r = $random(seed);
            p.mask = r[1:0];
            send_pkt(p, (r[4:2] == 3'b000) ? int'(r[6:5]) + 1 : 0);
        end
        waited = 0;
        while (exp_q.size() > 0) begin
            waited++;
            if (waited > TIMEOUT) fail_run("output drain timed out");
            @(posedge clk);
        end
        @(negedge clk);
        assert (!out_valid) else fail_run("output still valid after drain");
        $display("Test passed");
        $finish;
    end

endmodule
